/* src/block_bitmap.sv */
`timescale 1ns/1ps

module block_bitmap #(
   parameter int HBLKS = 64,
   parameter int VBLKS = 36,
   localparam int CW   = (HBLKS > 1) ? $clog2(HBLKS) : 1,
   localparam int RW   = (VBLKS > 1) ? $clog2(VBLKS) : 1
) (
   input  logic          vin_clk_i,
   input  logic          reset_i,
   input  logic          swap_i,
   input  logic          wr_en_i,
   input  logic [CW-1:0] wr_col_i,
   input  logic [RW-1:0] wr_row_i,
   input  logic          wr_bit_i,
   input  logic [CW-1:0] rd_col_i,
   input  logic [RW-1:0] rd_row_i,
   output logic          rd_bit_o
);

   localparam int NBITS = HBLKS * VBLKS;
   localparam int AW    = (NBITS > 1) ? $clog2(NBITS) : 1;

   logic [NBITS-1:0] bank_q [2];
   logic             sel_q; // bank being written this frame.
   logic [AW-1:0]    wr_addr;
   logic [AW-1:0]    rd_addr;

   assign wr_addr = AW'(int'(wr_row_i) * HBLKS + int'(wr_col_i));
   assign rd_addr = AW'(int'(rd_row_i) * HBLKS + int'(rd_col_i));

   always_ff @(posedge vin_clk_i) begin
      if (reset_i) begin
         sel_q     <= 1'b0;
         bank_q[0] <= '0;
         bank_q[1] <= '0;
         rd_bit_o  <= 1'b0;
      end else begin
         if (swap_i) begin
            sel_q <= ~sel_q;
         end
         if (wr_en_i) begin
            bank_q[sel_q][wr_addr] <= wr_bit_i;
         end
         rd_bit_o <= bank_q[~sel_q][rd_addr]; // previous frame's bank.
      end
   end

endmodule

/* src/block_cursor.sv */
`timescale 1ns/1ps

module block_cursor #(
   parameter int KH      = 30,
   parameter int KV      = 30,
   parameter int H_WIDTH = 1920,
   parameter int HBLKS   = 64,
   parameter int VBLKS   = 36,
   localparam int CW     = (HBLKS > 1) ? $clog2(HBLKS) : 1,
   localparam int RW     = (VBLKS > 1) ? $clog2(VBLKS) : 1
) (
   input  logic          vin_clk_i,
   input  logic          reset_i,
   input  logic          vs_i,
   input  logic          de_i,
   output logic [CW-1:0] block_col_o,
   output logic [RW-1:0] block_row_o,
   output logic          line_end_o,
   output logic          frame_start_o
);

   localparam int PW = (KH > 1) ? $clog2(KH) : 1;
   localparam int LW = (KV > 1) ? $clog2(KV) : 1;

   logic [PW-1:0] px_q;
   logic [CW-1:0] col_q;
   logic [LW-1:0] line_q;
   logic [RW-1:0] row_q;
   logic          vs_q;
   logic          px_last;
   logic          col_last;
   logic          line_last;
   logic          row_last;

   assign px_last   = (px_q == PW'(KH - 1));
   assign col_last  = (col_q == CW'(HBLKS - 1));
   assign line_last = (line_q == LW'(KV - 1));
   assign row_last  = (row_q == RW'(VBLKS - 1));

   assign frame_start_o = vs_i & ~vs_q; // vs rising edge.
   assign line_end_o    = de_i & px_last & col_last;
   assign block_col_o   = col_q;
   assign block_row_o   = row_q;

   always_ff @(posedge vin_clk_i) begin
      if (reset_i) begin
         vs_q   <= 1'b0;
         px_q   <= '0;
         col_q  <= '0;
         line_q <= '0;
         row_q  <= '0;
      end else begin
         vs_q <= vs_i;
         if (frame_start_o) begin
            px_q   <= '0;
            col_q  <= '0;
            line_q <= '0;
            row_q  <= '0;
         end else if (de_i) begin
            if (!px_last) begin
               px_q <= px_q + 1'b1;
            end else begin
               px_q <= '0;
               if (!col_last) begin
                  col_q <= col_q + 1'b1;
               end else begin
                  col_q <= '0; // end of line.
                  if (!line_last) begin
                     line_q <= line_q + 1'b1;
                  end else begin
                     line_q <= '0;
                     row_q  <= row_last ? '0 : row_q + 1'b1;
                  end
               end
            end
         end
      end
   end

   a_width_multiple: assert property (@(posedge vin_clk_i) disable iff (reset_i)
      (H_WIDTH % KH == 0) && (H_WIDTH / KH == HBLKS));

   // every active line must close on a block boundary.
   a_line_aligned: assert property (@(posedge vin_clk_i) disable iff (reset_i)
      $fell(de_i) |-> (px_q == '0 && col_q == '0));

endmodule

/* src/block_luma_accum.sv */
`timescale 1ns/1ps

module block_luma_accum #(
   parameter int KH    = 30,
   parameter int KV    = 30,
   parameter int HBLKS = 64,
   parameter int VBLKS = 36,
   localparam int CW   = (HBLKS > 1) ? $clog2(HBLKS) : 1,
   localparam int RW   = (VBLKS > 1) ? $clog2(VBLKS) : 1
) (
   input  logic              vin_clk_i,
   input  logic              reset_i,
   input  logic              de_i,
   input  fantasy_pkg::pixel_t data_i,
   input  logic [CW-1:0]     block_col_i,
   input  logic              line_end_i,
   input  logic              frame_start_i,
   output logic              wr_en_o,
   output logic [CW-1:0]     wr_col_o,
   output logic [RW-1:0]     wr_row_o,
   output logic              wr_bit_o
);

   import fantasy_pkg::*;

   localparam int PW   = (KH > 1) ? $clog2(KH) : 1;
   localparam int LW   = (KV > 1) ? $clog2(KV) : 1;
   localparam int PXS  = KH * KV;
   localparam int CNTW = $clog2(PXS + 1);

   logic [CNTW-1:0] acc_q [HBLKS]; // bright count per block column.
   logic [CNTW-1:0] acc_nx;
   logic [PW-1:0]   px_q;
   logic [LW-1:0]   line_q;
   logic [RW-1:0]   row_q;
   logic            bright;
   logic            blk_end;

   assign bright  = data_i[BRIGHT_BIT];
   assign acc_nx  = acc_q[block_col_i] + CNTW'(bright);
   assign blk_end = de_i & (px_q == PW'(KH - 1)) & (line_q == LW'(KV - 1));

   always_ff @(posedge vin_clk_i) begin
      if (reset_i) begin
         wr_en_o <= 1'b0;
         px_q    <= '0;
         line_q  <= '0;
         row_q   <= '0;
         for (int i = 0; i < HBLKS; i++) begin
            acc_q[i] <= '0;
         end
      end else begin
         wr_en_o <= 1'b0;
         if (frame_start_i) begin
            px_q   <= '0;
            line_q <= '0;
            row_q  <= '0;
            for (int i = 0; i < HBLKS; i++) begin
               acc_q[i] <= '0;
            end
         end else if (de_i) begin
            px_q <= (px_q == PW'(KH - 1)) ? '0 : px_q + 1'b1;
            if (blk_end) begin
               acc_q[block_col_i] <= '0;
               wr_en_o  <= 1'b1;
               wr_col_o <= block_col_i;
               wr_row_o <= row_q;
               wr_bit_o <= (2 * int'(acc_nx)) >= PXS; // majority, ties bright.
            end else begin
               acc_q[block_col_i] <= acc_nx;
            end
            if (line_end_i) begin
               if (line_q == LW'(KV - 1)) begin
                  line_q <= '0;
                  row_q  <= (row_q == RW'(VBLKS - 1)) ? '0 : row_q + 1'b1;
               end else begin
                  line_q <= line_q + 1'b1;
               end
            end
         end
      end
   end

   a_wr_col_range: assert property (@(posedge vin_clk_i) disable iff (reset_i)
      wr_en_o |-> (int'(wr_col_o) < HBLKS));

endmodule

/* src/fantasy_pkg.sv */
package fantasy_pkg;

   // blue in [7:0], green in [15:8], red in [23:16].
   typedef logic [23:0] pixel_t;

   // sw_i[1:0] effect selection.
   typedef enum logic [1:0] {
      mode_bitmap     = 2'd0, // invert where the block bit is set.
      mode_pass       = 2'd1, // never invert.
      mode_all        = 2'd2, // always invert.
      mode_inv_bitmap = 2'd3  // invert where the block bit is clear.
   } effect_mode_e;

   // top bit of the green channel marks a bright pixel.
   localparam int BRIGHT_BIT = 15;

endpackage

/* src/fantasy_top.sv */
`timescale 1ns/1ps

module fantasy_top #(
   parameter int H_WIDTH       = 1920,
   parameter int H_TOTAL       = 2200,
   parameter int V_HEIGHT      = 1080,
   parameter int KH            = 30,
   parameter int KV            = 30,
   parameter int HEARTBEAT_BIT = 26
) (
   input  logic                vin_clk_i,
   input  logic                reset_i,
   input  logic [3:0]          sw_i,
   input  logic                vin_hs_i,
   input  logic                vin_vs_i,
   input  logic                vin_de_i,
   input  fantasy_pkg::pixel_t vin_data_i,
   input  logic                vout_hpd_i,
   output logic [3:0]          led_o,
   output logic                vin_hpd_o,
   output fantasy_pkg::pixel_t vout_data_o,
   output logic                vout_hs_o,
   output logic                vout_vs_o,
   output logic                vout_de_o
);

   localparam int HBLKS = H_WIDTH / KH;
   localparam int VBLKS = V_HEIGHT / KV;
   localparam int CW    = (HBLKS > 1) ? $clog2(HBLKS) : 1;
   localparam int RW    = (VBLKS > 1) ? $clog2(VBLKS) : 1;

   if (H_TOTAL <= H_WIDTH) begin : g_no_blank
      $error("H_TOTAL must exceed H_WIDTH");
   end

   logic [CW-1:0] block_col;
   logic [RW-1:0] block_row;
   logic          line_end;
   logic          frame_start;
   logic          wr_en;
   logic [CW-1:0] wr_col;
   logic [RW-1:0] wr_row;
   logic          wr_bit;
   logic          rd_bit;

   block_cursor #(
      .KH (KH), .KV (KV), .H_WIDTH (H_WIDTH), .HBLKS (HBLKS), .VBLKS (VBLKS)
   ) i_cursor (
      .vin_clk_i (vin_clk_i), .reset_i (reset_i), .vs_i (vin_vs_i), .de_i (vin_de_i),
      .block_col_o (block_col), .block_row_o (block_row),
      .line_end_o (line_end), .frame_start_o (frame_start)
   );

   block_luma_accum #(.KH (KH), .KV (KV), .HBLKS (HBLKS), .VBLKS (VBLKS)) i_accum (
      .vin_clk_i (vin_clk_i), .reset_i (reset_i), .de_i (vin_de_i), .data_i (vin_data_i),
      .block_col_i (block_col), .line_end_i (line_end), .frame_start_i (frame_start),
      .wr_en_o (wr_en), .wr_col_o (wr_col), .wr_row_o (wr_row), .wr_bit_o (wr_bit)
   );

   block_bitmap #(.HBLKS (HBLKS), .VBLKS (VBLKS)) i_bitmap (
      .vin_clk_i (vin_clk_i), .reset_i (reset_i), .swap_i (frame_start),
      .wr_en_i (wr_en), .wr_col_i (wr_col), .wr_row_i (wr_row), .wr_bit_i (wr_bit),
      .rd_col_i (block_col), .rd_row_i (block_row), .rd_bit_o (rd_bit)
   );

   pixel_mixer #(.HEARTBEAT_BIT (HEARTBEAT_BIT)) i_mixer (
      .vin_clk_i (vin_clk_i), .reset_i (reset_i), .sw_i (sw_i),
      .hs_i (vin_hs_i), .vs_i (vin_vs_i), .de_i (vin_de_i), .data_i (vin_data_i),
      .block_bit_i (rd_bit), .vout_hpd_i (vout_hpd_i),
      .vout_data_o (vout_data_o), .vout_hs_o (vout_hs_o), .vout_vs_o (vout_vs_o),
      .vout_de_o (vout_de_o), .led_o (led_o), .vin_hpd_o (vin_hpd_o)
   );

endmodule

/* src/pixel_mixer.sv */
`timescale 1ns/1ps

module pixel_mixer #(
   parameter int HEARTBEAT_BIT = 26
) (
   input  logic                vin_clk_i,
   input  logic                reset_i,
   input  logic [3:0]          sw_i,
   input  logic                hs_i,
   input  logic                vs_i,
   input  logic                de_i,
   input  fantasy_pkg::pixel_t data_i,
   input  logic                block_bit_i,
   input  logic                vout_hpd_i,
   output fantasy_pkg::pixel_t vout_data_o,
   output logic                vout_hs_o,
   output logic                vout_vs_o,
   output logic                vout_de_o,
   output logic [3:0]          led_o,
   output logic                vin_hpd_o
);

   import fantasy_pkg::*;

   pixel_t                 data_d1;
   logic                   hs_d1;
   logic                   vs_d1;
   logic                   de_d1;
   effect_mode_e           mode;
   logic                   flag;
   logic                   flag_q;
   logic                   frame_tgl_q;
   logic [HEARTBEAT_BIT:0] beat_q;

   assign mode = effect_mode_e'(sw_i[1:0]);

   always_comb begin
      case (mode)
         mode_bitmap:     flag = block_bit_i;
         mode_pass:       flag = 1'b0;
         mode_all:        flag = 1'b1;
         mode_inv_bitmap: flag = ~block_bit_i;
         default:         flag = 1'b0;
      endcase
   end

   always_ff @(posedge vin_clk_i) begin
      data_d1     <= data_i; // lines up with the bitmap read.
      vout_data_o <= data_d1 ^ {24{flag}};
      if (reset_i) begin
         {hs_d1, vs_d1, de_d1}             <= 3'b000;
         {vout_hs_o, vout_vs_o, vout_de_o} <= 3'b000;
         flag_q      <= 1'b0;
         frame_tgl_q <= 1'b0;
         beat_q      <= '0;
      end else begin
         {hs_d1, vs_d1, de_d1}             <= {hs_i, vs_i, de_i};
         {vout_hs_o, vout_vs_o, vout_de_o} <= {hs_d1, vs_d1, de_d1};
         flag_q <= flag;
         beat_q <= beat_q + 1'b1;
         if (vs_d1 && !vout_vs_o) begin
            frame_tgl_q <= ~frame_tgl_q; // one toggle per output frame.
         end
      end
   end

   assign led_o     = {vout_hpd_i, frame_tgl_q, beat_q[HEARTBEAT_BIT], flag_q};
   assign vin_hpd_o = vout_hpd_i | sw_i[3];

endmodule

/* verification/fantasy_checker.sv */
`timescale 1ns/1ps

module fantasy_checker #(
   parameter int H_WIDTH       = 8,
   parameter int V_HEIGHT      = 4,
   parameter int KH            = 4,
   parameter int KV            = 2,
   parameter int HEARTBEAT_BIT = 3
) (
   input  logic                vin_clk_i,
   input  logic                reset_i,
   input  logic [3:0]          sw_i,
   input  logic                hs_i,
   input  logic                vs_i,
   input  logic                de_i,
   input  fantasy_pkg::pixel_t data_i,
   input  logic                vout_hpd_i,
   input  logic                exp_hpd_i,
   input  logic [3:0]          led_i,
   input  logic                vin_hpd_i,
   input  fantasy_pkg::pixel_t vout_data_i,
   input  logic                vout_hs_i,
   input  logic                vout_vs_i,
   input  logic                vout_de_i,
   output int                  sync_errors_o,
   output int                  data_errors_o,
   output int                  pin_errors_o,
   output int                  pixels_o
);

   import fantasy_pkg::*;

   localparam int HBLKS = H_WIDTH / KH;
   localparam int NBLK  = HBLKS * (V_HEIGHT / KV);

   int         bright_cnt [NBLK]; // bright pixels seen per block this frame.
   logic       prev_bit [NBLK];
   logic [2:0] sync_pipe [2];
   pixel_t     exp_pipe [2];
   logic       flag_pipe [2];
   logic       vs_last;
   logic       out_vs_last;
   logic       frame_tgl;
   logic       flag;
   int         beat_cnt; // cycles since reset.
   int         x;
   int         y;
   int         blk;

   function automatic logic inversion_for_mode(input logic [1:0] mode, input logic blk_bit);
      case (effect_mode_e'(mode))
         mode_bitmap: return blk_bit;
         mode_pass:   return 1'b0;
         mode_all:    return 1'b1;
         default:     return ~blk_bit;
      endcase
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
      $display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
   endtask

   // outputs settle after the rising edge, so everything is sampled on the falling edge.
   always @(negedge vin_clk_i) begin
      if (reset_i) begin
         {sync_errors_o, data_errors_o, pin_errors_o, pixels_o} = '0;
         {x, y, vs_last, out_vs_last, frame_tgl} = '0;
         beat_cnt = 0;
         for (int b = 0; b < NBLK; b++) begin
            bright_cnt[b] = 0;
            prev_bit[b]   = 1'b0;
         end
         for (int s = 0; s < 2; s++) begin
            sync_pipe[s] = '0;
            exp_pipe[s]  = '0;
            flag_pipe[s] = 1'b0;
         end
      end else begin
         if ({vout_hs_i, vout_vs_i, vout_de_i} !== sync_pipe[1]) begin
            report_mismatch("{vout_hs_o, vout_vs_o, vout_de_o}", sync_pipe[1],
                            {vout_hs_i, vout_vs_i, vout_de_i});
            sync_errors_o++;
         end
         if (vout_de_i) begin
            pixels_o++; // pixels that came out of the DUT.
         end
         if (sync_pipe[1][0]) begin
            if (vout_data_i !== exp_pipe[1]) begin
               report_mismatch("vout_data_o", exp_pipe[1], vout_data_i);
               data_errors_o++;
            end
            if (led_i[0] !== flag_pipe[1]) begin
               report_mismatch("led_o[0]", flag_pipe[1], led_i[0]);
               data_errors_o++;
            end
         end
         if (vin_hpd_i !== exp_hpd_i || led_i[3] !== vout_hpd_i) begin
            report_mismatch("{vin_hpd_o, led_o[3]}", {exp_hpd_i, vout_hpd_i},
                            {vin_hpd_i, led_i[3]});
            pin_errors_o++;
         end
         if (sync_pipe[1][1] && !out_vs_last) begin
            frame_tgl = ~frame_tgl; // one toggle per output frame.
         end
         out_vs_last = sync_pipe[1][1];
         if (led_i[2] !== frame_tgl || led_i[1] !== beat_cnt[HEARTBEAT_BIT]) begin
            report_mismatch("led_o[2:1]", {frame_tgl, beat_cnt[HEARTBEAT_BIT]}, led_i[2:1]);
            pin_errors_o++;
         end
         beat_cnt++;
         if (vs_i && !vs_last) begin
            for (int b = 0; b < NBLK; b++) begin
               prev_bit[b]   = (2 * bright_cnt[b]) >= (KH * KV); // half or more is bright.
               bright_cnt[b] = 0;
            end
            x = 0;
            y = 0;
         end
         vs_last = vs_i;
         flag    = 1'b0;
         if (de_i) begin
            blk  = (y / KV) * HBLKS + x / KH;
            flag = inversion_for_mode(sw_i[1:0], prev_bit[blk]);
            bright_cnt[blk] += int'(data_i[BRIGHT_BIT]);
            x++;
            if (x == H_WIDTH) begin
               x = 0;
               y++;
            end
         end
         sync_pipe[1] = sync_pipe[0];
         exp_pipe[1]  = exp_pipe[0];
         flag_pipe[1] = flag_pipe[0];
         sync_pipe[0] = {hs_i, vs_i, de_i};
         exp_pipe[0]  = data_i ^ {24{flag}};
         flag_pipe[0] = flag;
      end
   end

endmodule

/* verification/tb_fantasy.sv */
`timescale 1ns/1ps

module tb_fantasy;

   import fantasy_pkg::*;

   localparam int H_WIDTH       = 8;
   localparam int H_TOTAL       = 12;
   localparam int V_HEIGHT      = 4;
   localparam int KH            = 4;
   localparam int KV            = 2;
   localparam int HEARTBEAT_BIT = 3;
   localparam int HBLKS         = H_WIDTH / KH;
   localparam int NROWS         = 8;
   localparam int FORCED        = KH * KV / 2 + 1; // forced pixels per block fix its majority.
   localparam int PIXELS        = NROWS * H_WIDTH * V_HEIGHT;

   logic        clk;
   logic        reset;
   logic        hs;
   logic        vs;
   logic        de;
   logic        hpd;
   logic        exp_hpd;
   logic [3:0]  sw;
   logic [3:0]  bright;
   logic [3:0]  led;
   pixel_t      data;
   pixel_t      vout_data;
   logic        vin_hpd;
   logic        vout_hs;
   logic        vout_vs;
   logic        vout_de;
   logic [31:0] seed;
   int          sync_errors;
   int          data_errors;
   int          pin_errors;
   int          pixels;
   int          timeouts;

   // sw, vout_hpd, expected vin_hpd, bright blocks (bit row * HBLKS + col).
   logic [9:0] stim [NROWS] = '{
      {4'b0000, 1'b0, 1'b0, 4'b1010}, {4'b0000, 1'b1, 1'b1, 4'b0110},
      {4'b1011, 1'b0, 1'b1, 4'b1111}, {4'b1001, 1'b1, 1'b1, 4'b0000},
      {4'b0010, 1'b0, 1'b0, 4'b0101}, {4'b1000, 1'b0, 1'b1, 4'b1001},
      {4'b0011, 1'b1, 1'b1, 4'b0011}, {4'b0001, 1'b0, 1'b0, 4'b1100}
   };

   fantasy_top #(
      .H_WIDTH (H_WIDTH), .H_TOTAL (H_TOTAL), .V_HEIGHT (V_HEIGHT),
      .KH (KH), .KV (KV), .HEARTBEAT_BIT (HEARTBEAT_BIT)
   ) UUT (
      .vin_clk_i (clk), .reset_i (reset), .sw_i (sw), .vin_hs_i (hs), .vin_vs_i (vs),
      .vin_de_i (de), .vin_data_i (data), .vout_hpd_i (hpd), .led_o (led),
      .vin_hpd_o (vin_hpd), .vout_data_o (vout_data), .vout_hs_o (vout_hs),
      .vout_vs_o (vout_vs), .vout_de_o (vout_de)
   );

   fantasy_checker #(
      .H_WIDTH (H_WIDTH), .V_HEIGHT (V_HEIGHT), .KH (KH), .KV (KV),
      .HEARTBEAT_BIT (HEARTBEAT_BIT)
   ) i_checker (
      .vin_clk_i (clk), .reset_i (reset), .sw_i (sw), .hs_i (hs), .vs_i (vs), .de_i (de),
      .data_i (data), .vout_hpd_i (hpd), .exp_hpd_i (exp_hpd), .led_i (led),
      .vin_hpd_i (vin_hpd), .vout_data_i (vout_data), .vout_hs_i (vout_hs),
      .vout_vs_i (vout_vs), .vout_de_i (vout_de), .sync_errors_o (sync_errors),
      .data_errors_o (data_errors), .pin_errors_o (pin_errors), .pixels_o (pixels)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   // one sync line, one back porch line, then V_HEIGHT active lines.
   task automatic drive_frame(input logic [9:0] row);
      int blk;
      int pos;
      for (int l = 0; l < V_HEIGHT + 2; l++) begin
         for (int h = 0; h < H_TOTAL; h++) begin
            @(posedge clk);
            #1;
            if (l == 0 && h == 0) begin
               {sw, hpd, exp_hpd, bright} = row;
            end
            vs   = (l == 0);
            hs   = (h > H_WIDTH) && (h < H_WIDTH + 3);
            de   = (l >= 2) && (h < H_WIDTH);
            data = '0;
            if (de) begin
               blk  = ((l - 2) / KV) * HBLKS + h / KH;
               pos  = ((l - 2) % KV) * KH + h % KH;
               seed = xorshift32(seed);
               data = seed[23:0];
               if (pos < FORCED) begin
                  data[BRIGHT_BIT] = bright[blk];
               end
            end
         end
      end
   endtask

   initial begin
      int waited;
      {clk, hs, vs, de, hpd, exp_hpd} = '0;
      {sw, bright, data} = '0;
      reset    = 1'b1;
      seed     = 32'h2c581dfe;
      timeouts = 0;
      waited   = 0;
      repeat (10) @(posedge clk);
      #1 reset = 1'b0;
      for (int r = 0; r < NROWS; r++) begin
         drive_frame(stim[r]);
      end
      while (pixels < PIXELS && waited < 50) begin
         @(posedge clk);
         waited++;
      end
      if (pixels < PIXELS) begin
         $display("timeout: only %0d of %0d output pixels came out", pixels, PIXELS);
         timeouts++;
      end
      $display("summary: %0d sync, %0d data, %0d pin, %0d timeout errors",
               sync_errors, data_errors, pin_errors, timeouts);
      if (sync_errors + data_errors + pin_errors + timeouts == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* verilog.f */
src/fantasy_pkg.sv
src/block_cursor.sv
src/block_luma_accum.sv
src/block_bitmap.sv
src/pixel_mixer.sv
src/fantasy_top.sv
verification/fantasy_checker.sv
verification/tb_fantasy.sv
